// ==== hdl/rom_pkg.sv ====
// program ROM map shared by the loader, the PROM bank and the top level
// eight 8 KB PROMs: four main CPU program, four object graphics
`default_nettype none

package rom_pkg;

    // one PROM is 8 KB
    localparam int PROM_AW = 13;

    // 7a 7b 7c 7e, then 1e 1f 1j 1k
    localparam int PROM_COUNT = 8;

    // main CPU sees a 32 KB window, top two bits pick the bank
    localparam int MAIN_AW = 15;

    // download image is 64 KB in total
    // offsets 0..32767 fill the main PROMs in order 7a, 7b, 7c, 7e
    // offsets 32768..65535 fill the object PROMs in order 1e, 1f, 1j, 1k
    // the top three bits are the PROM index and the low 13 bits the PROM address
    localparam int DL_AW = 16;

    // load bus from the loader into the PROM bank
    typedef struct packed {
        logic [PROM_AW-1:0]    addr;  // address inside one PROM
        logic [7:0]            data;
        logic [PROM_COUNT-1:0] we;    // one-hot, bit i writes PROM i
    } prog_bus_t;

endpackage

`default_nettype wire

// ==== hdl/rom_prom.sv ====
// single-port-write, single-port-read PROM
// loaded through the write port, registered read on every edge
`timescale 1ns/1ps
`default_nettype none

module rom_prom
    import rom_pkg::*;
#(
    parameter int aw = PROM_AW
) (
    input  logic          clk,
    input  logic          we,
    input  logic [aw-1:0] wr_addr,
    input  logic [7:0]    data,
    input  logic [aw-1:0] rd_addr,
    output logic [7:0]    q
);

    logic [7:0] mem [0:(1<<aw)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;  // only during download
        end
        q <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/rom_loader.sv ====
// download loader
// turns the linear byte stream into one-hot PROM write strobes
// and raises rom_ready once a non-empty download has finished
`timescale 1ns/1ps
`default_nettype none

module rom_loader
    import rom_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic [DL_AW-1:0] dl_addr,
    input  logic [7:0]       dl_data,
    input  logic             dl_wr,
    input  logic             downloading,
    output prog_bus_t        prog,
    output logic             rom_ready
);

    logic                  accept;
    logic [PROM_COUNT-1:0] we_onehot;
    logic [PROM_COUNT-1:0] we_q;
    logic [PROM_AW-1:0]    addr_q;
    logic [7:0]            data_q;
    logic                  dl_prev;     // downloading, one edge late
    logic                  any_written; // sticky, set by the first byte

    // bytes only count while the download level is up
    assign accept = dl_wr && downloading;

    // top three address bits give the PROM index
    assign we_onehot = PROM_COUNT'(1) << dl_addr[DL_AW-1:PROM_AW];

    always_ff @(posedge clk) begin
        if (reset) begin
            we_q        <= '0;
            dl_prev     <= 1'b0;
            any_written <= 1'b0;
            rom_ready   <= 1'b0;
        end else begin
            we_q    <= accept ? we_onehot : '0;
            dl_prev <= downloading;
            if (downloading && !dl_prev) begin
                // a new download starts from scratch
                any_written <= 1'b0;
                rom_ready   <= 1'b0;
            end
            if (accept) begin
                any_written <= 1'b1;
            end
            if (!downloading && dl_prev) begin
                rom_ready <= any_written;  // empty download stays not ready
            end
        end
    end

    // payload, only meaningful together with we
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= dl_addr[PROM_AW-1:0];
            data_q <= dl_data;
        end
    end

    assign prog = '{addr: addr_q, data: data_q, we: we_q};

endmodule

`default_nettype wire

// ==== hdl/rom_bank.sv ====
// bank of eight PROMs
// main CPU reads one byte from the bank picked by the top address bits,
// object engine reads the same address from all four graphics PROMs
`timescale 1ns/1ps
`default_nettype none

module rom_bank
    import rom_pkg::*;
(
    input  logic               clk,
    input  prog_bus_t          prog,
    input  logic [MAIN_AW-1:0] main_addr,
    input  logic               main_cs,
    input  logic [PROM_AW-1:0] obj_addr,
    output logic [7:0]         main_dout,
    output logic [31:0]        obj_dout
);

    logic [7:0] main_q [4];
    logic [7:0] obj_q  [4];
    logic [1:0] bank_q;  // lines up with the PROM read data
    logic       cs_q;

    always_ff @(posedge clk) begin
        bank_q <= main_addr[MAIN_AW-1:PROM_AW];
        cs_q   <= main_cs;
    end

    // main byte only moves while the CPU selects the ROM
    always_ff @(posedge clk) begin
        if (cs_q) begin
            main_dout <= main_q[bank_q];
        end
    end

    // 1e in the low byte, 1k in the high byte
    always_ff @(posedge clk) begin
        obj_dout <= {obj_q[3], obj_q[2], obj_q[1], obj_q[0]};
    end

    // main CPU program, 7a 7b 7c 7e
    rom_prom u_main0 (
        .clk     (clk),
        .we      (prog.we[0]),
        .wr_addr (prog.addr),
        .data    (prog.data),
        .rd_addr (main_addr[PROM_AW-1:0]),
        .q       (main_q[0])
    );

    rom_prom u_main1 (
        .clk     (clk),
        .we      (prog.we[1]),
        .wr_addr (prog.addr),
        .data    (prog.data),
        .rd_addr (main_addr[PROM_AW-1:0]),
        .q       (main_q[1])
    );

    rom_prom u_main2 (
        .clk     (clk),
        .we      (prog.we[2]),
        .wr_addr (prog.addr),
        .data    (prog.data),
        .rd_addr (main_addr[PROM_AW-1:0]),
        .q       (main_q[2])
    );

    rom_prom u_main3 (
        .clk     (clk),
        .we      (prog.we[3]),
        .wr_addr (prog.addr),
        .data    (prog.data),
        .rd_addr (main_addr[PROM_AW-1:0]),
        .q       (main_q[3])
    );

    // object graphics, 1e 1f 1j 1k
    rom_prom u_obj0 (
        .clk     (clk),
        .we      (prog.we[4]),
        .wr_addr (prog.addr),
        .data    (prog.data),
        .rd_addr (obj_addr),
        .q       (obj_q[0])
    );

    rom_prom u_obj1 (
        .clk     (clk),
        .we      (prog.we[5]),
        .wr_addr (prog.addr),
        .data    (prog.data),
        .rd_addr (obj_addr),
        .q       (obj_q[1])
    );

    rom_prom u_obj2 (
        .clk     (clk),
        .we      (prog.we[6]),
        .wr_addr (prog.addr),
        .data    (prog.data),
        .rd_addr (obj_addr),
        .q       (obj_q[2])
    );

    rom_prom u_obj3 (
        .clk     (clk),
        .we      (prog.we[7]),
        .wr_addr (prog.addr),
        .data    (prog.data),
        .rd_addr (obj_addr),
        .q       (obj_q[3])
    );

endmodule

`default_nettype wire

// ==== hdl/rom_subsystem.sv ====
// program ROM subsystem
// download loader feeding the eight-PROM bank
`timescale 1ns/1ps
`default_nettype none

module rom_subsystem
    import rom_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    // download stream
    input  logic [DL_AW-1:0]   dl_addr,
    input  logic [7:0]         dl_data,
    input  logic               dl_wr,
    input  logic               downloading,
    // main CPU side
    input  logic [MAIN_AW-1:0] main_addr,
    input  logic               main_cs,
    output logic [7:0]         main_dout,
    // object engine side
    input  logic [PROM_AW-1:0] obj_addr,
    output logic [31:0]        obj_dout,
    output logic               rom_ready
);

    prog_bus_t prog;  // loader to bank

    rom_loader u_loader (
        .clk         (clk),
        .reset       (reset),
        .dl_addr     (dl_addr),
        .dl_data     (dl_data),
        .dl_wr       (dl_wr),
        .downloading (downloading),
        .prog        (prog),
        .rom_ready   (rom_ready)
    );

    rom_bank u_bank (
        .clk       (clk),
        .prog      (prog),
        .main_addr (main_addr),
        .main_cs   (main_cs),
        .obj_addr  (obj_addr),
        .main_dout (main_dout),
        .obj_dout  (obj_dout)
    );

endmodule

`default_nettype wire

// ==== tests/tb_rom_subsystem.sv ====
// directed testbench for the program ROM subsystem
// downloads a pseudo-random 64 KB image, then checks main CPU and object reads
`timescale 1ns/1ps
`default_nettype none

module tb_rom_subsystem
    import rom_pkg::*;
;

    logic               clk = 1'b0;
    logic               reset;
    logic [DL_AW-1:0]   dl_addr;
    logic [7:0]         dl_data;
    logic               dl_wr;
    logic               downloading;
    logic [MAIN_AW-1:0] main_addr;
    logic               main_cs;
    logic [PROM_AW-1:0] obj_addr;
    logic [7:0]         main_dout;
    logic [31:0]        obj_dout;
    logic               rom_ready;

    logic [7:0]  image [0:65535];  // reference copy of the download
    logic [31:0] rng;
    int          checks;
    int          errors;
    int          err_mark;
    string       cur_test;

    always #2 clk = ~clk;

    rom_subsystem u_dut (
        .clk         (clk),
        .reset       (reset),
        .dl_addr     (dl_addr),
        .dl_data     (dl_data),
        .dl_wr       (dl_wr),
        .downloading (downloading),
        .main_addr   (main_addr),
        .main_cs     (main_cs),
        .main_dout   (main_dout),
        .obj_addr    (obj_addr),
        .obj_dout    (obj_dout),
        .rom_ready   (rom_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", cur_test, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        $display("test %s finished, %0d errors", cur_test, errors - err_mark);
    endtask

    // data shows up two edges after the address is driven
    task automatic read_main(input logic [MAIN_AW-1:0] addr);
        @(posedge clk);
        main_addr <= addr;
        main_cs   <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check(32'(image[addr]), 32'(main_dout));
    endtask

    task automatic read_obj(input logic [PROM_AW-1:0] addr);
        logic [31:0] expected;
        expected = {image[57344 + int'(addr)], image[49152 + int'(addr)],
                    image[40960 + int'(addr)], image[32768 + int'(addr)]};
        @(posedge clk);
        obj_addr <= addr;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check(expected, obj_dout);
    endtask

    task automatic download_image();
        @(posedge clk);
        downloading <= 1'b1;
        for (int i = 0; i < 65536; i++) begin
            @(posedge clk);
            dl_addr <= DL_AW'(i);
            dl_data <= image[i];
            dl_wr   <= 1'b1;
        end
        @(posedge clk);
        dl_wr <= 1'b0;
        @(posedge clk);
        downloading <= 1'b0;  // end of download
    endtask

    task automatic wait_ready(input int limit);
        int n = 0;
        while (rom_ready !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (rom_ready !== 1'b1) begin
            errors++;
            $display("rom_ready did not rise within %0d cycles after the download", limit);
        end
    endtask

    task automatic reset_and_ready();
        begin_test("reset_ready");
        @(negedge clk);
        check(32'(1'b0), 32'(rom_ready));
        download_image();
        wait_ready(16);
        end_test();
    endtask

    task automatic main_reads();
        logic [MAIN_AW-1:0] edges [10] = '{15'h0000, 15'h0001, 15'h1FFF, 15'h2000,
                                           15'h3FFF, 15'h4000, 15'h5FFF, 15'h6000,
                                           15'h7FFE, 15'h7FFF};
        begin_test("main_reads");
        foreach (edges[i]) begin
            read_main(edges[i]);
        end
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            read_main(rng[MAIN_AW-1:0]);
        end
        end_test();
    endtask

    task automatic cs_hold();
        logic [MAIN_AW-1:0] other;
        begin_test("cs_hold");
        other = 15'h5678;
        while (image[other] === image[16'h1234]) begin
            other++;  // needs a byte that differs from the held one
        end
        read_main(15'h1234);
        @(posedge clk);
        main_addr <= other;
        main_cs   <= 1'b0;  // deselected, output must hold
        repeat (4) @(posedge clk);
        @(negedge clk);
        check(32'(image[16'h1234]), 32'(main_dout));
        end_test();
    endtask

    task automatic obj_reads();
        logic [PROM_AW-1:0] edges [4] = '{13'h0000, 13'h0001, 13'h1000, 13'h1FFF};
        begin_test("obj_reads");
        foreach (edges[i]) begin
            read_obj(edges[i]);
        end
        for (int i = 0; i < 8; i++) begin
            rng = xorshift(rng);
            read_obj(rng[PROM_AW-1:0]);
        end
        end_test();
    endtask

    task automatic ignored_writes();
        logic [DL_AW-1:0] offs [4] = '{16'h0005, 16'h2000, 16'h8003, 16'hFFFF};
        begin_test("ignored_writes");
        foreach (offs[i]) begin
            @(posedge clk);
            dl_addr <= offs[i];
            dl_data <= ~image[offs[i]];
            dl_wr   <= 1'b1;  // downloading stays low
            @(posedge clk);
            dl_wr <= 1'b0;
        end
        repeat (3) @(posedge clk);
        read_main(15'h0005);
        read_main(15'h2000);
        read_obj(13'h0003);
        read_obj(13'h1FFF);
        check(32'(1'b1), 32'(rom_ready));
        end_test();
    endtask

    initial begin
        reset       = 1'b1;
        dl_addr     = '0;
        dl_data     = '0;
        dl_wr       = 1'b0;
        downloading = 1'b0;
        main_addr   = '0;
        main_cs     = 1'b0;
        obj_addr    = '0;
        checks      = 0;
        errors      = 0;
        rng         = 32'd15555;
        for (int i = 0; i < 65536; i++) begin
            rng      = xorshift(rng);
            image[i] = rng[7:0];
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        reset_and_ready();
        main_reads();
        cs_hold();
        obj_reads();
        ignored_writes();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/rom_pkg.sv
hdl/rom_prom.sv
hdl/rom_loader.sv
hdl/rom_bank.sv
hdl/rom_subsystem.sv
tests/tb_rom_subsystem.sv

// ==== Makefile ====
TOP := tb_rom_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Regression passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log
